// File: verilog/rvCore_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// data word width.
`define RV_XLEN 32

// unified memory depth in words, indexed by byte address bits 9:2.
`define RV_MEM_WORDS 256

// first fetch address after reset.
`define RV_RESET_PC 32'h0000_0000

`endif

// File: verilog/rvPkg.sv
`include "rvCore_settings.svh"

package rvPkg;

    // word index width of the unified memory.
    localparam int MEM_AW = $clog2(`RV_MEM_WORDS);

    // major opcodes of the supported subset.
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // write-back source select.
    localparam logic [1:0] WB_ALU = 2'd0;
    localparam logic [1:0] WB_MEM = 2'd1;
    localparam logic [1:0] WB_PC4 = 2'd2;

    // upper immediate select.
    localparam logic [1:0] UP_AUIPC = 2'd0;
    localparam logic [1:0] UP_LUI   = 2'd1;
    localparam logic [1:0] UP_NONE  = 2'd2;

    typedef struct packed {
        logic       branch;
        logic       memRead;
        logic       memWrite;
        logic       aluSrc;
        logic       regWrite;
        logic       halt;
        logic [1:0] memToReg;
        logic [1:0] upperSel;
        logic       isJump;
    } ctrlT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOpT;

    typedef struct packed {
        logic [MEM_AW-1:0]   addr;
        logic [`RV_XLEN-1:0] wdata;
        logic                write;
    } memReqT;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rdata;
    } memRspT;

endpackage

// File: verilog/mainControl.sv
`timescale 1ns/10ps

module mainControl (
    input  logic [6:0]  opcode,
    output rvPkg::ctrlT ctrl
);

    import rvPkg::*;

    always_comb begin
        // unknown opcodes fall through as no-ops.
        ctrl = '0;
        case (opcode)
            OP_R: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = WB_ALU;
                ctrl.upperSel = UP_NONE;
            end
            OP_I: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = WB_ALU;
                ctrl.upperSel = UP_NONE;
            end
            OP_LOAD: begin
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = WB_MEM;
                ctrl.upperSel = UP_NONE;
            end
            OP_STORE: begin
                // write only, no read strobe.
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.upperSel = UP_NONE;
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.upperSel = UP_NONE;
            end
            OP_JAL: begin
                ctrl.isJump   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = WB_PC4;
                ctrl.upperSel = UP_NONE;
            end
            OP_LUI, OP_AUIPC: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = WB_ALU;
                // split the upper-immediate class.
                case (opcode)
                    OP_AUIPC: ctrl.upperSel = UP_AUIPC;
                    default:  ctrl.upperSel = UP_LUI;
                endcase
            end
            OP_SYSTEM: begin
                // ecall stops the core.
                ctrl.halt     = 1'b1;
                ctrl.upperSel = UP_NONE;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module regFile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1Addr,
    input  logic [4:0]          rs2Addr,
    input  logic [4:0]          rdAddr,
    input  logic [`RV_XLEN-1:0] rdData,
    input  logic                writeEn,
    output logic [`RV_XLEN-1:0] rs1Data,
    output logic [`RV_XLEN-1:0] rs2Data
);

    // x0 has no storage.
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rdAddr != 5'd0)) begin
            regs[rdAddr] <= rdData;
        end
    end

    // combinational reads, x0 reads as zero.
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module execUnit (
    input  logic [`RV_XLEN-1:0] instr,
    input  logic [`RV_XLEN-1:0] pc,
    input  rvPkg::ctrlT         ctrl,
    input  logic [`RV_XLEN-1:0] rs1Data,
    input  logic [`RV_XLEN-1:0] rs2Data,
    output logic [`RV_XLEN-1:0] result,
    output logic [`RV_XLEN-1:0] nextPc,
    output logic [`RV_XLEN-1:0] storeData
);

    import rvPkg::*;

    logic [`RV_XLEN-1:0] immI, immS, immB, immJ, immU;
    logic [`RV_XLEN-1:0] opB, aluOut, pcPlus4;
    logic [2:0]          funct3;
    logic [6:0]          opcode;
    logic                zero, taken;
    aluOpT               aluOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // immediate formats.
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    assign opB = ctrl.aluSrc ? (ctrl.memWrite ? immS : immI) : rs2Data;

    always_comb begin
        aluOp = ALU_ADD;
        if (ctrl.branch) begin
            aluOp = ALU_SUB;
        end else if ((opcode == OP_R) || (opcode == OP_I)) begin
            case (funct3)
                3'b000:  aluOp = ((opcode == OP_R) && instr[30]) ? ALU_SUB : ALU_ADD;
                3'b010:  aluOp = ALU_SLT;
                3'b100:  aluOp = ALU_XOR;
                3'b110:  aluOp = ALU_OR;
                3'b111:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            ALU_SUB: aluOut = rs1Data - opB;
            ALU_AND: aluOut = rs1Data & opB;
            ALU_OR:  aluOut = rs1Data | opB;
            ALU_XOR: aluOut = rs1Data ^ opB;
            ALU_SLT: aluOut = {{(`RV_XLEN-1){1'b0}}, $signed(rs1Data) < $signed(opB)};
            default: aluOut = rs1Data + opB;
        endcase
    end

    // beq on funct3 bit 0 clear, bne when set.
    assign zero  = (aluOut == '0);
    assign taken = ctrl.branch && (funct3[0] ? !zero : zero);

    assign pcPlus4 = pc + `RV_XLEN'd4;

    always_comb begin
        if (ctrl.memToReg == WB_PC4) begin
            result = pcPlus4;
        end else begin
            case (ctrl.upperSel)
                UP_AUIPC: result = pc + immU;
                UP_LUI:   result = immU;
                default:  result = aluOut;
            endcase
        end
    end

    assign nextPc    = ctrl.isJump ? (pc + immJ) : (taken ? (pc + immB) : pcPlus4);
    assign storeData = rs2Data;

endmodule

// File: verilog/memArbiter.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module memArbiter (
    input  logic                       clk,
    input  logic                       reset,
    input  rvPkg::memReqT              hostReq,
    input  logic                       hostValid,
    output logic                       hostReady,
    input  rvPkg::memReqT              dataReq,
    input  logic                       dataValid,
    output logic                       dataReady,
    input  rvPkg::memReqT              fetchReq,
    input  logic                       fetchValid,
    output logic                       fetchReady,
    output rvPkg::memRspT              hostRsp,
    output logic                       hostRspValid,
    output rvPkg::memRspT              dataRsp,
    output logic                       dataRspValid,
    output rvPkg::memRspT              fetchRsp,
    output logic                       fetchRspValid,
    output logic                       memEn,
    output logic                       memWrite,
    output logic [rvPkg::MEM_AW-1:0]   memAddr,
    output logic [`RV_XLEN-1:0]        memWdata,
    input  logic [`RV_XLEN-1:0]        memRdata
);

    import rvPkg::*;

    typedef struct packed {
        logic host;
        logic data;
        logic fetch;
    } ownerT;

    ownerT  grant;
    ownerT  readPend;
    memReqT sel;

    // ##########################################################################
    // fixed priority, host over data over fetch.
    // ##########################################################################

    assign grant.host  = hostValid;
    assign grant.data  = dataValid && !hostValid;
    assign grant.fetch = fetchValid && !hostValid && !dataValid;

    assign hostReady  = grant.host;
    assign dataReady  = grant.data;
    assign fetchReady = grant.fetch;

    assign sel = grant.host ? hostReq : (grant.data ? dataReq : fetchReq);

    assign memEn    = grant.host || grant.data || grant.fetch;
    assign memWrite = sel.write;
    assign memAddr  = sel.addr;
    assign memWdata = sel.wdata;

    // ##########################################################################
    // remember who owns the read in flight.
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            readPend <= '0;
        end else begin
            readPend <= memEn && !sel.write ? grant : '0;
        end
    end

    assign hostRspValid  = readPend.host;
    assign dataRspValid  = readPend.data;
    assign fetchRspValid = readPend.fetch;

    assign hostRsp.rdata  = readPend.host  ? memRdata : '0;
    assign dataRsp.rdata  = readPend.data  ? memRdata : '0;
    assign fetchRsp.rdata = readPend.fetch ? memRdata : '0;

endmodule

// File: verilog/unifiedMem.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module unifiedMem (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     write,
    input  logic [rvPkg::MEM_AW-1:0] addr,
    input  logic [`RV_XLEN-1:0]      wdata,
    output logic [`RV_XLEN-1:0]      rdata
);

    logic [`RV_XLEN-1:0] mem [0:`RV_MEM_WORDS-1];

    // single port, read data one cycle after enable.
    always_ff @(posedge clk) begin
        if (en) begin
            if (write) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: verilog/rvCore.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module rvCore (
    input  logic          clk,
    input  logic          reset,
    input  logic          run,
    output rvPkg::memReqT fetchReq,
    output logic          fetchValid,
    input  logic          fetchReady,
    input  rvPkg::memRspT fetchRsp,
    input  logic          fetchRspValid,
    output rvPkg::memReqT dataReq,
    output logic          dataValid,
    input  logic          dataReady,
    input  rvPkg::memRspT dataRsp,
    input  logic          dataRspValid,
    output logic          halted
);

    import rvPkg::*;

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_MEM, S_WB, S_HALT} stateT;

    stateT               state;
    logic                reqSent;
    logic [`RV_XLEN-1:0] pc, instr, loadData, resultQ, nextPcQ;
    logic [`RV_XLEN-1:0] rs1Data, rs2Data, result, nextPc, storeData, rdData;
    logic                regWriteEn;
    ctrlT                ctrl;

    mainControl u_mainControl (.opcode(instr[6:0]), .ctrl(ctrl));

    regFile u_regFile (
        .clk(clk), .reset(reset),
        .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]), .rdAddr(instr[11:7]),
        .rdData(rdData), .writeEn(regWriteEn),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    execUnit u_execUnit (
        .instr(instr), .pc(pc), .ctrl(ctrl), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .result(result), .nextPc(nextPc), .storeData(storeData)
    );

    // ##########################################################################
    // sequencer.
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            reqSent <= 1'b0;
            pc      <= `RV_RESET_PC;
        end else begin
            case (state)
                S_IDLE: if (run) state <= S_FETCH;
                S_FETCH: begin
                    if (!reqSent) begin
                        if (fetchValid && fetchReady) reqSent <= 1'b1;
                    end else if (fetchRspValid) begin
                        reqSent <= 1'b0;
                        state   <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (ctrl.halt) state <= S_HALT;
                    else if (ctrl.memRead || ctrl.memWrite) state <= S_MEM;
                    else state <= S_WB;
                end
                S_MEM: begin
                    // stores finish at the handshake, loads wait for data.
                    if (!reqSent) begin
                        if (dataValid && dataReady) begin
                            if (ctrl.memWrite) state <= S_WB;
                            else reqSent <= 1'b1;
                        end
                    end else if (dataRspValid) begin
                        reqSent <= 1'b0;
                        state   <= S_WB;
                    end
                end
                S_WB: begin
                    pc    <= nextPcQ;
                    state <= S_FETCH;
                end
                S_HALT: state <= S_HALT;
                default: state <= S_IDLE;
            endcase
        end
    end

    // instruction, execute results and load data.
    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && fetchRspValid) instr <= fetchRsp.rdata;
        if (state == S_EXEC) begin
            resultQ <= result;
            nextPcQ <= nextPc;
        end
        if ((state == S_MEM) && dataRspValid) loadData <= dataRsp.rdata;
    end

    assign fetchValid     = (state == S_FETCH) && !reqSent;
    assign fetchReq.addr  = pc[MEM_AW+1:2];
    assign fetchReq.wdata = '0;
    assign fetchReq.write = 1'b0;

    assign dataValid     = (state == S_MEM) && !reqSent;
    assign dataReq.addr  = resultQ[MEM_AW+1:2];
    assign dataReq.wdata = storeData;
    assign dataReq.write = ctrl.memWrite;

    assign regWriteEn = (state == S_WB) && ctrl.regWrite;
    assign rdData     = (ctrl.memToReg == WB_MEM) ? loadData : resultQ;
    assign halted     = (state == S_HALT);

endmodule

// File: verilog/rvTop.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module rvTop (
    input  logic          clk,
    input  logic          reset,
    input  logic          run,
    input  rvPkg::memReqT hostReq,
    input  logic          hostValid,
    output logic          hostReady,
    output rvPkg::memRspT hostRsp,
    output logic          hostRspValid,
    output logic          halted
);

    import rvPkg::*;

    memReqT              fetchReq, dataReq;
    memRspT              fetchRsp, dataRsp;
    logic                fetchValid, fetchReady, fetchRspValid;
    logic                dataValid, dataReady, dataRspValid;
    logic                memEn, memWrite;
    logic [MEM_AW-1:0]   memAddr;
    logic [`RV_XLEN-1:0] memWdata, memRdata;

    rvCore u_rvCore (
        .clk(clk), .reset(reset), .run(run),
        .fetchReq(fetchReq), .fetchValid(fetchValid), .fetchReady(fetchReady),
        .fetchRsp(fetchRsp), .fetchRspValid(fetchRspValid),
        .dataReq(dataReq), .dataValid(dataValid), .dataReady(dataReady),
        .dataRsp(dataRsp), .dataRspValid(dataRspValid),
        .halted(halted)
    );

    memArbiter u_memArbiter (
        .clk(clk), .reset(reset),
        .hostReq(hostReq), .hostValid(hostValid), .hostReady(hostReady),
        .dataReq(dataReq), .dataValid(dataValid), .dataReady(dataReady),
        .fetchReq(fetchReq), .fetchValid(fetchValid), .fetchReady(fetchReady),
        .hostRsp(hostRsp), .hostRspValid(hostRspValid),
        .dataRsp(dataRsp), .dataRspValid(dataRspValid),
        .fetchRsp(fetchRsp), .fetchRspValid(fetchRspValid),
        .memEn(memEn), .memWrite(memWrite), .memAddr(memAddr),
        .memWdata(memWdata), .memRdata(memRdata)
    );

    unifiedMem u_unifiedMem (
        .clk(clk), .en(memEn), .write(memWrite), .addr(memAddr),
        .wdata(memWdata), .rdata(memRdata)
    );

endmodule

// File: sim/rvTop_tb.sv
`timescale 1ns/10ps
`include "rvCore_settings.svh"

module rvTop_tb;

    import rvPkg::*;

    // six programs of up to 40 instructions at 8 cycles is under 2000 cycles.
    // host loading and readback add a few hundred more on top of that.
    localparam int CYCLE_LIMIT = 20000;
    // results are stored from byte address 0x200 on.
    localparam logic [MEM_AW-1:0] RESULT_WORD = 8'd128;

    logic   clk;
    logic   reset;
    logic   run;
    memReqT hostReq;
    logic   hostValid;
    logic   hostReady;
    memRspT hostRsp;
    logic   hostRspValid;
    logic   halted;

    int                  seed = 32'h261a;
    int                  cycles;
    int                  errors;
    int                  testErrors;
    int                  testsRun;
    logic [`RV_XLEN-1:0] prog[$];
    logic [`RV_XLEN-1:0] expected[$];
    logic [`RV_XLEN-1:0] shadow[0:`RV_MEM_WORDS-1];

    rvTop u_rvTop (
        .clk(clk), .reset(reset), .run(run),
        .hostReq(hostReq), .hostValid(hostValid), .hostReady(hostReady),
        .hostRsp(hostRsp), .hostRspValid(hostRspValid),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    // ##########################################################################
    // instruction encoding.
    // ##########################################################################

    function automatic logic [31:0] rOp(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iOp(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] upper(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] signExt12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // lui plus addi with the upper part rounded for the signed low half.
    task automatic emitConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(upper(7'b0110111, rd, hi[19:0]));
        emit(iOp(3'b000, rd, rd, value[11:0]));
    endtask

    // ##########################################################################
    // host port and run control.
    // ##########################################################################

    task automatic checkWord(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        $display("test %s done, %0d errors", name, testErrors);
        errors += testErrors;
        testErrors = 0;
        testsRun++;
    endtask

    task automatic resetCore();
        @(negedge clk);
        reset = 1'b1;
        run   = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    // the host has top priority and is granted in the cycle it asks.
    task automatic awaitHostGrant();
        if (!hostReady) begin
            $display("host request was not granted in its first cycle at t=%0t", $time);
            testErrors++;
        end
        while (!hostReady) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic hostWrite(input logic [MEM_AW-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        hostReq.addr  = addr;
        hostReq.wdata = data;
        hostReq.write = 1'b1;
        hostValid     = 1'b1;
        #1;
        awaitHostGrant();
        @(negedge clk);
        hostValid = 1'b0;
        shadow[addr] = data;
    endtask

    // the response must show up in the cycle right after the transfer.
    task automatic hostRead(input logic [MEM_AW-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        hostReq.addr  = addr;
        hostReq.wdata = '0;
        hostReq.write = 1'b0;
        hostValid     = 1'b1;
        #1;
        if (hostRspValid) begin
            $display("host response seen before the read was accepted at t=%0t", $time);
            testErrors++;
        end
        awaitHostGrant();
        @(negedge clk);
        hostValid = 1'b0;
        if (!hostRspValid) begin
            $display("no host response one cycle after the accepted read at t=%0t", $time);
            testErrors++;
            data = 'x;
        end else begin
            data = hostRsp.rdata;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            hostWrite(i, prog[i]);
        end
    endtask

    task automatic runUntilHalt();
        @(negedge clk);
        run = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        run = 1'b0;
    endtask

    task automatic checkResults();
        logic [31:0] got;
        for (int k = 0; k < expected.size(); k++) begin
            hostRead(RESULT_WORD + k, got);
            checkWord($sformatf("mem[%0d]", RESULT_WORD + k), expected[k], got);
        end
    endtask

    task automatic runAndCheck(input string name);
        resetCore();
        loadProgram();
        runUntilHalt();
        checkResults();
        finishTest(name);
    endtask

    // ##########################################################################
    // directed tests.
    // ##########################################################################

    task automatic hostAccessTest();
        logic [MEM_AW-1:0] addrs[8];
        logic [31:0]       got;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed);
            hostWrite(addrs[i], $random(seed));
        end
        // read back in reverse order against the shadow copy.
        for (int i = 7; i >= 0; i--) begin
            hostRead(addrs[i], got);
            checkWord($sformatf("hostRsp.rdata[%0d]", addrs[i]), shadow[addrs[i]], got);
        end
        finishTest("host access");
    endtask

    // registers x3..x13 hold R and I results and x0 follows a write attempt.
    task automatic buildAluProgram();
        logic [31:0] a, b, immX;
        logic [11:0] imm;
        a    = $random(seed);
        b    = $random(seed);
        imm  = $random(seed);
        // opposite signs make signed and unsigned compares disagree.
        a[31] = ~b[31];
        immX = signExt12(imm);
        prog.delete();
        expected.delete();
        emitConst(1, a);
        emitConst(2, b);
        emit(rOp(7'h00, 3'b000, 3, 1, 2));
        emit(rOp(7'h20, 3'b000, 4, 1, 2));
        emit(rOp(7'h00, 3'b111, 5, 1, 2));
        emit(rOp(7'h00, 3'b110, 6, 1, 2));
        emit(rOp(7'h00, 3'b100, 7, 1, 2));
        emit(rOp(7'h00, 3'b010, 8, 1, 2));
        emit(iOp(3'b000, 9, 1, imm));
        emit(iOp(3'b111, 10, 1, imm));
        emit(iOp(3'b110, 11, 1, imm));
        emit(iOp(3'b100, 12, 1, imm));
        emit(iOp(3'b010, 13, 1, imm));
        emit(rOp(7'h00, 3'b000, 0, 1, 2));
        expected.push_back(a + b);
        expected.push_back(a - b);
        expected.push_back(a & b);
        expected.push_back(a | b);
        expected.push_back(a ^ b);
        expected.push_back(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expected.push_back(a + immX);
        expected.push_back(a & immX);
        expected.push_back(a | immX);
        expected.push_back(a ^ immX);
        expected.push_back(($signed(a) < $signed(immX)) ? 32'd1 : 32'd0);
        expected.push_back(32'd0);
        emit(iOp(3'b000, 31, 0, 12'h200));
        for (int k = 0; k < 12; k++) begin
            emit(sw((k < 11) ? k + 3 : 0, 31, k * 4));
        end
        emit(32'h0000_0073);
    endtask

    task automatic aluTest();
        buildAluProgram();
        runAndCheck("alu");
    endtask

    task automatic loadStoreTest();
        logic [31:0] v;
        v = $random(seed);
        prog.delete();
        expected.delete();
        emitConst(1, v);
        emit(iOp(3'b000, 31, 0, 12'h200));
        emit(sw(1, 31, 12'd0));
        emit(lw(2, 31, 12'd0));
        emit(sw(2, 31, 12'd4));
        emit(32'h0000_0073);
        expected.push_back(v);
        expected.push_back(v);
        hostWrite(RESULT_WORD, ~v);
        hostWrite(RESULT_WORD + 1, ~v);
        runAndCheck("load store");
    endtask

    task automatic controlFlowTest();
        logic [31:0] n, jalPc;
        n = 3 + ($unsigned($random(seed)) % 8);
        prog.delete();
        expected.delete();
        emit(iOp(3'b000, 1, 0, n[11:0]));
        emit(iOp(3'b000, 2, 0, 12'd0));
        // loop body counts iterations in x2.
        emit(iOp(3'b000, 2, 2, 12'd1));
        emit(iOp(3'b000, 1, 1, 12'hfff));
        emit(branch(3'b001, 1, 0, -13'sd8));
        jalPc = prog.size() * 4;
        emit(jal(5, 21'd12));
        emit(iOp(3'b000, 2, 2, 12'd100));
        emit(iOp(3'b000, 2, 2, 12'd100));
        emit(iOp(3'b000, 31, 0, 12'h200));
        emit(branch(3'b000, 1, 0, 13'd8));
        emit(iOp(3'b000, 2, 2, 12'd100));
        emit(sw(2, 31, 12'd0));
        emit(sw(5, 31, 12'd4));
        emit(32'h0000_0073);
        expected.push_back(n);
        expected.push_back(jalPc + 4);
        runAndCheck("control flow");
    endtask

    task automatic upperImmTest();
        logic [19:0] u1, u2;
        logic [31:0] auipcPc;
        u1 = $random(seed);
        u2 = $random(seed);
        prog.delete();
        expected.delete();
        emit(iOp(3'b000, 31, 0, 12'h200));
        emit(upper(7'b0110111, 1, u1));
        auipcPc = prog.size() * 4;
        emit(upper(7'b0010111, 2, u2));
        emit(sw(1, 31, 12'd0));
        emit(sw(2, 31, 12'd4));
        emit(32'h0000_0073);
        expected.push_back({u1, 12'b0});
        expected.push_back(auipcPc + {u2, 12'b0});
        runAndCheck("upper immediate");
    endtask

    // host reads steal memory cycles from fetch and data while the program runs.
    task automatic contentionTest();
        logic [MEM_AW-1:0] addr;
        logic [31:0]       got;
        int                reads;
        buildAluProgram();
        for (int i = 0; i < 8; i++) begin
            hostWrite(200 + i, $random(seed));
        end
        resetCore();
        loadProgram();
        reads = 0;
        @(negedge clk);
        run = 1'b1;
        while (!halted) begin
            addr = 200 + (reads % 8);
            hostRead(addr, got);
            checkWord($sformatf("hostRsp.rdata[%0d]", addr), shadow[addr], got);
            reads++;
        end
        run = 1'b0;
        checkResults();
        finishTest("contention");
    endtask

    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        hostValid  = 1'b0;
        hostReq    = '0;
        errors     = 0;
        testErrors = 0;
        testsRun   = 0;
        resetCore();
        hostAccessTest();
        aluTest();
        loadStoreTest();
        controlFlowTest();
        upperImmTest();
        contentionTest();
        $display("tests run %0d, errors %0d", testsRun, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/rvPkg.sv
verilog/mainControl.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/memArbiter.sv
verilog/unifiedMem.sv
verilog/rvCore.sv
verilog/rvTop.sv
sim/rvTop_tb.sv

// File: Bender.yml
package:
  name: rvTop

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rvPkg.sv
      - verilog/mainControl.sv
      - verilog/regFile.sv
      - verilog/execUnit.sv
      - verilog/memArbiter.sv
      - verilog/unifiedMem.sv
      - verilog/rvCore.sv
      - verilog/rvTop.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/rvTop_tb.sv
